// File: noc_route_consts.svh
`ifndef NOC_ROUTE_CONSTS_SVH
`define NOC_ROUTE_CONSTS_SVH

// Router location coordinates.
`define NOC_ID_X_WIDTH 3
`define NOC_ID_Y_WIDTH 3

// Data word carried by every flit.
`define NOC_PAYLOAD_WIDTH 32

// Virtual channels on the input port.
`define NOC_VCS 2

// Entries in each channel buffer.
`define NOC_FIFO_DEPTH 4

// X plus, X minus, Y plus, Y minus and local.
`define NOC_PORTS 5

`endif

// File: noc_route_pkg.sv
package noc_route_pkg;

  `include "noc_route_consts.svh"

  // Dimension order used for this packet.
  typedef enum logic [0:0] {
    XY = 1'b0,
    YX = 1'b1
  } noc_routing_mode_e;

  // Header view of the data word in a head flit.
  typedef struct packed {
    noc_routing_mode_e                mode;
    logic [`NOC_ID_X_WIDTH-1:0]       dest_x;
    logic [`NOC_ID_Y_WIDTH-1:0]       dest_y;
    logic [`NOC_ID_X_WIDTH-1:0]       src_x;
    logic [`NOC_ID_Y_WIDTH-1:0]       src_y;
    logic [`NOC_PAYLOAD_WIDTH - 1 - 2 * `NOC_ID_X_WIDTH
           - 2 * `NOC_ID_Y_WIDTH - 1:0] reserved;
  } noc_header_t;

  // Head flits read the word as a header, body and tail flits as raw data.
  typedef union packed {
    noc_header_t                      header;
    logic [`NOC_PAYLOAD_WIDTH-1:0]    payload;
  } noc_flit_data_u;

  // Single-flit packets set both head and tail.
  typedef struct packed {
    logic           head;
    logic           tail;
    noc_flit_data_u data;
  } noc_flit_t;

  // One-hot direction.
  // Bit 0 X plus, 1 X minus, 2 Y plus, 3 Y minus, 4 local; zero is no route.
  typedef logic [`NOC_PORTS-1:0] noc_route_t;

endpackage

// File: flit_input_buffer.sv
`include "noc_route_consts.svh"
`timescale 1ns/100ps

module flit_input_buffer
  import noc_route_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  output logic      in_ready,
  input  noc_flit_t in_flit,
  output logic      out_valid,
  input  logic      out_ready,
  output noc_flit_t out_flit
);

  localparam int DEPTH  = `NOC_FIFO_DEPTH;
  localparam int AW     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW     = $clog2(DEPTH + 1);

  noc_flit_t        mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             push;
  logic             pop;
  logic             full;

  assign full      = (count == CW'(DEPTH));
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];

  assign pop  = out_valid && out_ready;
  // A pop in the same cycle frees room for the push.
  assign in_ready = !full || pop;
  assign push = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: route_selector.sv
`include "noc_route_consts.svh"
`timescale 1ns/100ps

module route_selector
  import noc_route_pkg::*;
#(
  parameter logic [`NOC_PORTS-1:0] AVAILABLE_PORTS = 5'b11111
)(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`NOC_ID_X_WIDTH-1:0]  my_x,
  input  logic [`NOC_ID_Y_WIDTH-1:0]  my_y,
  input  logic [`NOC_VCS-1:0]         buf_valid,
  input  noc_flit_t                   buf_flit [`NOC_VCS],
  output logic [`NOC_VCS-1:0]         buf_ready,
  output logic [`NOC_VCS-1:0]         port_request [`NOC_PORTS],
  input  logic [`NOC_VCS-1:0]         port_grant [`NOC_PORTS],
  input  logic [`NOC_PORTS-1:0]       out_ready
);

  function automatic noc_route_t select_route(
    input noc_header_t                hdr,
    input logic [`NOC_ID_X_WIDTH-1:0] x,
    input logic [`NOC_ID_Y_WIDTH-1:0] y
  );
    logic [1:0] x_hit;
    logic [1:0] y_hit;
    noc_route_t route;

    x_hit[0] = (hdr.dest_x > x) && AVAILABLE_PORTS[0];
    x_hit[1] = (hdr.dest_x < x) && AVAILABLE_PORTS[1];
    y_hit[0] = (hdr.dest_y > y) && AVAILABLE_PORTS[2];
    y_hit[1] = (hdr.dest_y < y) && AVAILABLE_PORTS[3];
    route    = '0;

    // Plus and minus never hit together, so each pair is already one-hot.
    if (hdr.mode == XY) begin
      if (|x_hit) begin
        route[1:0] = x_hit;
      end else if (|y_hit) begin
        route[3:2] = y_hit;
      end else begin
        route[4] = 1'b1;
      end
    end else begin
      if (|y_hit) begin
        route[3:2] = y_hit;
      end else if (|x_hit) begin
        route[1:0] = x_hit;
      end else begin
        route[4] = 1'b1;
      end
    end
    return route;
  endfunction

  noc_route_t route_of [`NOC_VCS];

  for (genvar v = 0; v < `NOC_VCS; v++) begin : g_channel
    noc_flit_t  flit;
    logic       head_valid;
    logic       flit_done;
    noc_route_t route_next;
    noc_route_t route_held;

    assign flit       = buf_flit[v];
    assign head_valid = buf_valid[v] && flit.head;
    assign flit_done  = buf_valid[v] && buf_ready[v];
    assign route_next = select_route(flit.data.header, my_x, my_y);

    // Head flit routes directly, the rest of the packet uses the latch.
    assign route_of[v] = head_valid ? route_next : route_held;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        route_held <= '0;
      end else if (flit_done && flit.tail) begin
        route_held <= '0;
      end else if (flit_done && flit.head) begin
        route_held <= route_next;
      end
    end
  end

  always_comb begin
    for (int v = 0; v < `NOC_VCS; v++) begin
      buf_ready[v] = 1'b0;
      for (int p = 0; p < `NOC_PORTS; p++) begin
        port_request[p][v] = route_of[v][p] && buf_valid[v];
        if (route_of[v][p] && port_grant[p][v] && out_ready[p]) begin
          buf_ready[v] = 1'b1;
        end
      end
    end
  end

endmodule

// File: vc_output_merger.sv
`include "noc_route_consts.svh"
`timescale 1ns/100ps

module vc_output_merger
  import noc_route_pkg::*;
#(
  localparam int VC_W = (`NOC_VCS > 1) ? $clog2(`NOC_VCS) : 1
)(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [`NOC_VCS-1:0] request,
  output logic [`NOC_VCS-1:0] grant,
  input  noc_flit_t           in_flit [`NOC_VCS],
  output logic                out_valid,
  input  logic                out_ready,
  output noc_flit_t           out_flit,
  output logic [VC_W-1:0]     out_vc
);

  logic             locked;
  logic [VC_W-1:0]  lock_vc;
  logic [VC_W-1:0]  rr_ptr;
  logic [VC_W-1:0]  pick_vc;
  logic [VC_W-1:0]  sel;
  logic             out_done;

  // Round-robin search starting at the pointer.
  always_comb begin
    int   idx;
    logic found;

    found   = 1'b0;
    pick_vc = rr_ptr;
    for (int i = 0; i < `NOC_VCS; i++) begin
      idx = (int'(rr_ptr) + i) % `NOC_VCS;
      if (!found && request[idx]) begin
        found   = 1'b1;
        pick_vc = VC_W'(idx);
      end
    end
  end

  assign sel       = locked ? lock_vc : pick_vc;
  assign grant     = request & (`NOC_VCS'(1) << sel);
  assign out_valid = |grant;
  assign out_flit  = in_flit[sel];
  assign out_vc    = sel;
  assign out_done  = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      locked  <= 1'b0;
      lock_vc <= '0;
      rr_ptr  <= '0;
    end else if (out_done && out_flit.tail) begin
      locked <= 1'b0;
      rr_ptr <= (sel == VC_W'(`NOC_VCS - 1)) ? '0 : sel + 1'b1;
    end else if (out_valid) begin
      // Also holds a stalled head so the offered flit cannot change.
      locked  <= 1'b1;
      lock_vc <= sel;
    end
  end

endmodule

// File: route_unit_top.sv
`include "noc_route_consts.svh"
`timescale 1ns/100ps

module route_unit_top
  import noc_route_pkg::*;
#(
  parameter  logic [`NOC_PORTS-1:0] AVAILABLE_PORTS = 5'b11111,
  localparam int                    VC_W = (`NOC_VCS > 1) ? $clog2(`NOC_VCS) : 1
)(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`NOC_ID_X_WIDTH-1:0]  my_x,
  input  logic [`NOC_ID_Y_WIDTH-1:0]  my_y,
  input  logic [`NOC_VCS-1:0]         in_valid,
  output logic [`NOC_VCS-1:0]         in_ready,
  input  noc_flit_t                   in_flit [`NOC_VCS],
  output logic [`NOC_PORTS-1:0]       out_valid,
  input  logic [`NOC_PORTS-1:0]       out_ready,
  output noc_flit_t                   out_flit [`NOC_PORTS],
  output logic [VC_W-1:0]             out_vc [`NOC_PORTS]
);

  logic [`NOC_VCS-1:0]  buf_valid;
  logic [`NOC_VCS-1:0]  buf_ready;
  noc_flit_t            buf_flit [`NOC_VCS];
  logic [`NOC_VCS-1:0]  port_request [`NOC_PORTS];
  logic [`NOC_VCS-1:0]  port_grant [`NOC_PORTS];

  for (genvar v = 0; v < `NOC_VCS; v++) begin : g_buffer
    flit_input_buffer u_buffer (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid[v]),
      .in_ready  (in_ready[v]),
      .in_flit   (in_flit[v]),
      .out_valid (buf_valid[v]),
      .out_ready (buf_ready[v]),
      .out_flit  (buf_flit[v])
    );
  end

  route_selector #(
    .AVAILABLE_PORTS (AVAILABLE_PORTS)
  ) u_selector (
    .clk          (clk),
    .rst_n        (rst_n),
    .my_x         (my_x),
    .my_y         (my_y),
    .buf_valid    (buf_valid),
    .buf_flit     (buf_flit),
    .buf_ready    (buf_ready),
    .port_request (port_request),
    .port_grant   (port_grant),
    .out_ready    (out_ready)
  );

  for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_merger
    vc_output_merger u_merger (
      .clk       (clk),
      .rst_n     (rst_n),
      .request   (port_request[p]),
      .grant     (port_grant[p]),
      .in_flit   (buf_flit),
      .out_valid (out_valid[p]),
      .out_ready (out_ready[p]),
      .out_flit  (out_flit[p]),
      .out_vc    (out_vc[p])
    );
  end

endmodule

// File: route_unit_properties.sv
`include "noc_route_consts.svh"
`timescale 1ns/100ps

module route_unit_properties
  import noc_route_pkg::*;
#(
  localparam int VC_W = (`NOC_VCS > 1) ? $clog2(`NOC_VCS) : 1
)(
  input logic                  clk,
  input logic                  rst_n,
  input logic [`NOC_PORTS-1:0] out_valid,
  input logic [`NOC_PORTS-1:0] out_ready,
  input noc_flit_t             out_flit [`NOC_PORTS],
  input logic [VC_W-1:0]       out_vc [`NOC_PORTS],
  input logic [`NOC_VCS-1:0]   grant [`NOC_PORTS]
);

  logic [`NOC_PORTS-1:0] vc_grant [`NOC_VCS];

  // Grants seen by each channel across all directions.
  always_comb begin
    for (int v = 0; v < `NOC_VCS; v++) begin
      for (int p = 0; p < `NOC_PORTS; p++) begin
        vc_grant[v][p] = grant[p][v];
      end
    end
  end

  for (genvar v = 0; v < `NOC_VCS; v++) begin : g_channel
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(vc_grant[v]))
      else $error("channel %0d granted on more than one port", v);
  end

  for (genvar p = 0; p < `NOC_PORTS; p++) begin : g_port
    // A stalled flit is held unchanged.
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[p] && !out_ready[p] |=> out_valid[p] && $stable(out_flit[p]))
      else $error("port %0d changed a stalled flit", p);

    // Channel stays fixed until the tail leaves.
    a_vc_locked: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[p] && out_ready[p] && !out_flit[p].tail |=> $stable(out_vc[p]))
      else $error("port %0d switched channel inside a packet", p);
  end

endmodule

bind route_unit_top route_unit_properties u_properties (
  .clk       (clk),
  .rst_n     (rst_n),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_flit  (out_flit),
  .out_vc    (out_vc),
  .grant     (port_grant)
);

// File: route_unit_tb.sv
`include "noc_route_consts.svh"
`timescale 1ns/100ps

module route_unit_tb
  import noc_route_pkg::*;
;

  localparam int VCS            = `NOC_VCS;
  localparam int PORTS          = `NOC_PORTS;
  localparam int XW             = `NOC_ID_X_WIDTH;
  localparam int YW             = `NOC_ID_Y_WIDTH;
  localparam int VC_W           = (VCS > 1) ? $clog2(VCS) : 1;
  localparam int NUM_PACKETS    = 40;
  localparam int MAX_FLITS      = 4;
  localparam int TIMEOUT_CYCLES = NUM_PACKETS * MAX_FLITS * VCS * 8;

  localparam logic [PORTS-1:0] AVAIL = 5'b01011;
  localparam logic [XW-1:0]    MY_X  = XW'(3);
  localparam logic [YW-1:0]    MY_Y  = YW'(3);

  logic            clk;
  logic            rst_n;
  logic [XW-1:0]   my_x;
  logic [YW-1:0]   my_y;
  logic [VCS-1:0]  in_valid;
  logic [VCS-1:0]  in_ready;
  noc_flit_t       in_flit [VCS];
  logic [PORTS-1:0] out_valid;
  logic [PORTS-1:0] out_ready;
  noc_flit_t       out_flit [PORTS];
  logic [VC_W-1:0] out_vc [PORTS];

  // Flits still to send per channel, flits owed per channel and direction.
  noc_flit_t stim_q [VCS][$];
  noc_flit_t exp_q [VCS*PORTS][$];

  int        pending;
  int        checked;
  int        value_errors;
  int        other_errors;
  int        cycles;
  logic      pkt_open [PORTS];
  logic [VC_W-1:0] pkt_vc [PORTS];

  route_unit_top #(
    .AVAILABLE_PORTS (AVAIL)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .my_x      (my_x),
    .my_y      (my_y),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_flit   (in_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_flit  (out_flit),
    .out_vc    (out_vc)
  );

  always #2 clk = ~clk;

  // Dimension order routing with unavailable directions skipped.
  function automatic int expected_port(input noc_header_t hdr);
    int x_dir;
    int y_dir;

    x_dir = -1;
    y_dir = -1;
    if (hdr.dest_x > MY_X && AVAIL[0]) x_dir = 0;
    if (hdr.dest_x < MY_X && AVAIL[1]) x_dir = 1;
    if (hdr.dest_y > MY_Y && AVAIL[2]) y_dir = 2;
    if (hdr.dest_y < MY_Y && AVAIL[3]) y_dir = 3;
    if (hdr.mode == XY) begin
      return (x_dir >= 0) ? x_dir : ((y_dir >= 0) ? y_dir : 4);
    end
    return (y_dir >= 0) ? y_dir : ((x_dir >= 0) ? x_dir : 4);
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      value_errors++;
    end
  endtask

  task automatic build_traffic();
    noc_flit_t   f;
    noc_header_t hdr;
    int          len;
    int          port;

    for (int v = 0; v < VCS; v++) begin
      for (int k = 0; k < NUM_PACKETS; k++) begin
        len          = $urandom_range(1, MAX_FLITS);
        hdr.mode     = noc_routing_mode_e'(1'($urandom_range(0, 1)));
        hdr.dest_x   = XW'($urandom_range(0, 7));
        hdr.dest_y   = YW'($urandom_range(0, 7));
        hdr.src_x    = MY_X;
        hdr.src_y    = MY_Y;
        hdr.reserved = '0;
        port         = expected_port(hdr);
        for (int i = 0; i < len; i++) begin
          f.head = (i == 0);
          f.tail = (i == len - 1);
          if (i == 0) begin
            f.data.header = hdr;
          end else begin
            f.data.payload = $urandom;
          end
          stim_q[v].push_back(f);
          exp_q[v*PORTS + port].push_back(f);
          pending++;
        end
      end
    end
  endtask

  // Scoreboard on every output handshake.
  always @(posedge clk) begin : monitor
    int        idx;
    noc_flit_t exp_flit;

    if (rst_n) begin
      for (int p = 0; p < PORTS; p++) begin
        if (out_valid[p] && out_ready[p]) begin
          idx = int'(out_vc[p]) * PORTS + p;
          checked++;
          if (exp_q[idx].size() == 0) begin
            $display("Unexpected flit on port %0d from channel %0d", p, out_vc[p]);
            other_errors++;
          end else begin
            exp_flit = exp_q[idx].pop_front();
            check_value("out_flit", 64'(out_flit[p]), 64'(exp_flit));
            pending--;
          end
          if (pkt_open[p]) begin
            check_value("out_vc", 64'(out_vc[p]), 64'(pkt_vc[p]));
            if (out_flit[p].head) begin
              $display("Packets interleaved on port %0d", p);
              other_errors++;
            end
          end
          if (out_flit[p].head) pkt_vc[p] = out_vc[p];
          pkt_open[p] = !out_flit[p].tail;
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: traffic did not drain within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin : stimulus
    int        seed_draw;
    noc_flit_t dropped;
    int        left;

    seed_draw    = $urandom(72449);
    clk          = 1'b0;
    rst_n        = 1'b0;
    my_x         = MY_X;
    my_y         = MY_Y;
    in_valid     = '0;
    out_ready    = '0;
    pending      = 0;
    checked      = 0;
    value_errors = 0;
    other_errors = 0;
    cycles       = 0;
    for (int v = 0; v < VCS; v++) in_flit[v] = '0;
    for (int p = 0; p < PORTS; p++) begin
      pkt_open[p] = 1'b0;
      pkt_vc[p]   = '0;
    end
    build_traffic();

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("out_valid", 64'(out_valid), 64'(0));
    check_value("in_ready", 64'(in_ready), 64'({`NOC_VCS{1'b1}}));

    left = pending;
    while (left > 0 || in_valid != '0 || pending > 0) begin
      @(posedge clk);
      // Each output ready about three cycles out of four.
      out_ready <= PORTS'($urandom_range(0, 31)) | PORTS'($urandom_range(0, 31));
      left = 0;
      for (int v = 0; v < VCS; v++) begin
        if (!in_valid[v] || in_ready[v]) begin
          if (in_valid[v]) dropped = stim_q[v].pop_front();
          if (stim_q[v].size() > 0 && $urandom_range(0, 3) != 0) begin
            in_valid[v] <= 1'b1;
            in_flit[v]  <= stim_q[v][0];
          end else begin
            in_valid[v] <= 1'b0;
          end
        end
        left += stim_q[v].size();
      end
    end

    repeat (4) @(posedge clk);
    $display("Flits checked: %0d, value errors: %0d, other errors: %0d",
             checked, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: noc_route.f
+incdir+.
noc_route_pkg.sv
flit_input_buffer.sv
route_selector.sv
vc_output_merger.sv
route_unit_top.sv
route_unit_properties.sv
route_unit_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := route_unit_tb
FILELIST   := noc_route.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
